// ==== hdl/uart_params.svh ====
`ifndef UART_PARAMS_SVH
`define UART_PARAMS_SVH

// sample ticks per bit.
`define UART_OVS 16

// received frames held before the CPU reads them.
`define UART_FIFO_DEPTH 4

// register offsets.
`define UART_ADDR_DATA   12'h000
`define UART_ADDR_STATUS 12'h004
`define UART_ADDR_CTRL   12'h008

// clk cycles per sample tick, minus one.
`define UART_DIV_RESET 16'd1

`endif

// ==== hdl/uart_pkg.sv ====
`default_nettype none

package uart_pkg;

  // one received character.
  typedef logic [7:0] data_t;

  // clk cycles per sample tick minus one.
  typedef logic [15:0] div_t;

  // laid out to match the DATA register bits 9..0.
  typedef struct packed {
    logic  frame_err;
    logic  parity_err;
    data_t data;
  } rx_frame_t;

  typedef enum logic [2:0] {
    IDLE,
    START,
    DATA,
    PARITY,
    STOP,
    DONE
  } rx_state_e;

endpackage

`default_nettype wire

// ==== hdl/apb_pkg.sv ====
`default_nettype none

package apb_pkg;

  typedef logic [11:0] addr_t;
  typedef logic [31:0] word_t;

  typedef struct packed {
    logic  psel;
    logic  penable;
    logic  pwrite;
    addr_t paddr;
    word_t pwdata;
  } apb_req_t;

  typedef struct packed {
    logic  pready;
    word_t prdata;
    logic  pslverr;
  } apb_rsp_t;

endpackage

`default_nettype wire

// ==== hdl/baud_tick_gen.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "uart_params.svh"

module baud_tick_gen (
  input  logic           clk,
  input  logic           reset,
  input  uart_pkg::div_t divisor,
  output logic           tick_16x
);

  uart_pkg::div_t count;
  uart_pkg::div_t div_q;   // last divisor seen.

  always_ff @(posedge clk) begin
    if (reset) begin
      count    <= `UART_DIV_RESET;
      div_q    <= `UART_DIV_RESET;
      tick_16x <= 1'b0;
    end else begin
      div_q <= divisor;
      if (divisor != div_q) begin
        // new rate, start a full period.
        count    <= divisor;
        tick_16x <= 1'b0;
      end else if (count == '0) begin
        count    <= divisor;
        tick_16x <= 1'b1;
      end else begin
        count    <= count - 1'b1;
        tick_16x <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// ==== hdl/uart_rx.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "uart_params.svh"

module uart_rx (
  input  logic                clk,
  input  logic                reset,
  input  logic                tick_16x,
  input  logic                rx_pin,
  input  logic                parity_enable,
  output uart_pkg::rx_frame_t frame,
  output logic                frame_valid
);

  localparam int OVS_W = $clog2(`UART_OVS);
  localparam logic [OVS_W-1:0] MID_TICK  = OVS_W'(`UART_OVS / 2);
  localparam logic [OVS_W-1:0] LAST_TICK = OVS_W'(`UART_OVS - 1);

  uart_pkg::rx_state_e state;
  logic                rx_meta;
  logic                rx_sync;
  logic                rx_prev;
  logic [OVS_W-1:0]    os_cnt;
  logic [2:0]          bit_idx;
  uart_pkg::data_t     shift;
  logic                par_err;
  logic                stop_err;
  logic                mid_tick;
  logic                last_tick;

  assign mid_tick  = tick_16x && (os_cnt == MID_TICK);
  assign last_tick = tick_16x && (os_cnt == LAST_TICK);

  // two-flop synchronizer plus previous sample for edge detect.
  always_ff @(posedge clk) begin
    if (reset) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end else begin
      rx_meta <= rx_pin;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state       <= uart_pkg::IDLE;
      os_cnt      <= '0;
      frame_valid <= 1'b0;
    end else begin
      frame_valid <= 1'b0;
      if (tick_16x) os_cnt <= os_cnt + 1'b1;   // wraps at the bit end.
      case (state)
        uart_pkg::IDLE: begin
          os_cnt <= '0;
          if (rx_prev && !rx_sync) state <= uart_pkg::START;
        end
        uart_pkg::START: begin
          if (mid_tick && rx_sync) state <= uart_pkg::IDLE;   // glitch.
          else if (last_tick) state <= uart_pkg::DATA;
        end
        uart_pkg::DATA: begin
          if (last_tick && bit_idx == 3'd7) begin
            state <= parity_enable ? uart_pkg::PARITY : uart_pkg::STOP;
          end
        end
        uart_pkg::PARITY: begin
          if (last_tick) state <= uart_pkg::STOP;
        end
        uart_pkg::STOP: begin
          if (last_tick) state <= uart_pkg::DONE;
        end
        uart_pkg::DONE: begin
          if (tick_16x) begin
            frame_valid <= 1'b1;
            // line already low after a good stop bit: next start bit.
            if (!stop_err && !rx_sync) state <= uart_pkg::START;
            else state <= uart_pkg::IDLE;
          end
        end
        default: state <= uart_pkg::IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    case (state)
      uart_pkg::START: begin
        if (last_tick) begin
          bit_idx <= '0;
          par_err <= 1'b0;
        end
      end
      uart_pkg::DATA: begin
        if (mid_tick) shift <= {rx_sync, shift[7:1]};   // lsb first.
        if (last_tick) bit_idx <= bit_idx + 1'b1;
      end
      uart_pkg::PARITY: begin
        if (mid_tick) par_err <= (rx_sync != ~^shift);   // odd parity.
      end
      uart_pkg::STOP: begin
        if (mid_tick) stop_err <= !rx_sync;
      end
      uart_pkg::DONE: begin
        if (tick_16x) begin
          frame.data       <= shift;
          frame.parity_err <= par_err;
          frame.frame_err  <= stop_err;
        end
      end
      default: ;
    endcase
  end

  a_valid_single: assert property (@(posedge clk) disable iff (reset)
    frame_valid |=> !frame_valid);

  a_state_legal: assert property (@(posedge clk) disable iff (reset)
    state inside {uart_pkg::IDLE, uart_pkg::START, uart_pkg::DATA,
                  uart_pkg::PARITY, uart_pkg::STOP, uart_pkg::DONE});

endmodule

`default_nettype wire

// ==== hdl/rx_fifo.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "uart_params.svh"

module rx_fifo (
  input  logic                clk,
  input  logic                reset,
  input  logic                push,
  input  logic                pop,
  input  uart_pkg::rx_frame_t din,
  output uart_pkg::rx_frame_t head,
  output logic                empty,
  output logic                full,
  output logic                overrun
);

  localparam int DEPTH = `UART_FIFO_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);
  localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1);

  uart_pkg::rx_frame_t mem [DEPTH];
  logic [PTR_W-1:0]    wr_ptr;
  logic [PTR_W-1:0]    rd_ptr;
  logic [CNT_W-1:0]    count;
  logic                pop_ok;
  logic                push_ok;

  assign empty   = (count == '0);
  assign full    = (count == CNT_W'(DEPTH));
  assign pop_ok  = pop && !empty;
  assign push_ok = push && (!full || pop_ok);   // a pop frees the slot.
  assign head    = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (push_ok) mem[wr_ptr] <= din;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count   <= '0;
      overrun <= 1'b0;
    end else begin
      overrun <= push && !push_ok;
      if (push_ok) wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
      if (pop_ok) rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
      case ({push_ok, pop_ok})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ;
      endcase
    end
  end

  a_count_bound: assert property (@(posedge clk) disable iff (reset)
    count <= CNT_W'(DEPTH));

  // the register block only pops a non-empty FIFO.
  a_no_pop_empty: assert property (@(posedge clk) disable iff (reset)
    pop |-> !empty);

endmodule

`default_nettype wire

// ==== hdl/apb_uart_regs.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "uart_params.svh"

module apb_uart_regs (
  input  logic                clk,
  input  logic                reset,
  input  apb_pkg::apb_req_t   req,
  output apb_pkg::apb_rsp_t   rsp,
  input  uart_pkg::rx_frame_t head,
  input  logic                empty,
  input  logic                full,
  input  logic                overrun,
  output logic                pop,
  output logic                parity_enable,
  output uart_pkg::div_t      divisor
);

  logic           access;
  logic           is_data;
  logic           is_status;
  logic           is_ctrl;
  logic           addr_ok;
  logic           overrun_q;   // sticky.
  apb_pkg::word_t rd_data;

  assign access    = req.psel && req.penable;
  assign is_data   = (req.paddr == `UART_ADDR_DATA);
  assign is_status = (req.paddr == `UART_ADDR_STATUS);
  assign is_ctrl   = (req.paddr == `UART_ADDR_CTRL);
  assign addr_ok   = is_data || is_status || is_ctrl;

  assign pop = access && !req.pwrite && is_data && !empty;

  always_comb begin
    rd_data = '0;
    if (is_data) begin
      if (!empty) rd_data = {21'd0, 1'b1, head};   // bit 10 is valid.
    end else if (is_status) begin
      rd_data = {29'd0, overrun_q, full, empty};
    end else if (is_ctrl) begin
      rd_data = {divisor, 15'd0, parity_enable};
    end
  end

  assign rsp.pready  = 1'b1;   // zero wait states.
  assign rsp.prdata  = rd_data;
  assign rsp.pslverr = access && !addr_ok;

  always_ff @(posedge clk) begin
    if (reset) begin
      parity_enable <= 1'b0;
      divisor       <= `UART_DIV_RESET;
      overrun_q     <= 1'b0;
    end else begin
      if (access && req.pwrite && is_ctrl) begin
        parity_enable <= req.pwdata[0];
        divisor       <= req.pwdata[31:16];
      end
      // a new overrun beats a clear in the same cycle.
      if (overrun) begin
        overrun_q <= 1'b1;
      end else if (access && req.pwrite && is_status && req.pwdata[2]) begin
        overrun_q <= 1'b0;
      end
    end
  end

  a_penable_in_psel: assert property (@(posedge clk) disable iff (reset)
    $rose(req.penable) |-> req.psel);

endmodule

`default_nettype wire

// ==== hdl/uart_apb_top.sv ====
`default_nettype none
`timescale 1ns/1ps

module uart_apb_top (
  input  logic              clk,
  input  logic              reset,
  input  logic              rx_pin,
  input  apb_pkg::apb_req_t req,
  output apb_pkg::apb_rsp_t rsp
);

  uart_pkg::div_t      divisor;
  logic                parity_enable;
  logic                tick_16x;
  uart_pkg::rx_frame_t frame;
  logic                frame_valid;
  uart_pkg::rx_frame_t head;
  logic                empty;
  logic                full;
  logic                overrun;
  logic                pop;

  baud_tick_gen u_baud (
    .clk      (clk),
    .reset    (reset),
    .divisor  (divisor),
    .tick_16x (tick_16x)
  );

  uart_rx u_rx (
    .clk           (clk),
    .reset         (reset),
    .tick_16x      (tick_16x),
    .rx_pin        (rx_pin),
    .parity_enable (parity_enable),
    .frame         (frame),
    .frame_valid   (frame_valid)
  );

  // no back-pressure, a full FIFO drops the frame.
  rx_fifo u_fifo (
    .clk     (clk),
    .reset   (reset),
    .push    (frame_valid),
    .pop     (pop),
    .din     (frame),
    .head    (head),
    .empty   (empty),
    .full    (full),
    .overrun (overrun)
  );

  apb_uart_regs u_regs (
    .clk           (clk),
    .reset         (reset),
    .req           (req),
    .rsp           (rsp),
    .head          (head),
    .empty         (empty),
    .full          (full),
    .overrun       (overrun),
    .pop           (pop),
    .parity_enable (parity_enable),
    .divisor       (divisor)
  );

endmodule

`default_nettype wire

// ==== verification/tb_uart_apb.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "uart_params.svh"

module tb_uart_apb;

  localparam int DIV      = 2;
  localparam int BIT_CLKS = `UART_OVS * (DIV + 1);
  localparam int TIMEOUT  = 40 * 11 * `UART_OVS * (DIV + 1) * 2 + 2000;

  logic              clk;
  logic              reset;
  logic              rx_pin;
  apb_pkg::apb_req_t req;
  apb_pkg::apb_rsp_t rsp;

  integer         seed;
  int             cycles;
  int             checks;
  int             value_errs;
  int             other_errs;
  apb_pkg::word_t model_q[$];   // expected DATA words.
  logic           model_ovr;
  apb_pkg::word_t ctrl_model;

  uart_apb_top DUT (
    .clk    (clk),
    .reset  (reset),
    .rx_pin (rx_pin),
    .req    (req),
    .rsp    (rsp)
  );

  always #2 clk = ~clk;

  task automatic compare(input string name, input apb_pkg::word_t exp,
                         input apb_pkg::word_t act);
    checks++;
    if (act !== exp) begin
      value_errs++;
      $display("error %s: expected %h, got %h", name, exp, act);
    end
  endtask

  // setup cycle then access cycle with the response sampled mid access.
  task automatic apb_xfer(input logic wr, input apb_pkg::addr_t addr,
                          input apb_pkg::word_t wdata, output apb_pkg::word_t rdata);
    logic bad_addr;
    bad_addr = !(addr inside {`UART_ADDR_DATA, `UART_ADDR_STATUS, `UART_ADDR_CTRL});
    @(posedge clk);
    req.psel    <= 1'b1;
    req.penable <= 1'b0;
    req.pwrite  <= wr;
    req.paddr   <= addr;
    req.pwdata  <= wdata;
    @(posedge clk);
    req.penable <= 1'b1;
    @(negedge clk);
    rdata = rsp.prdata;
    compare("pready", 32'd1, {31'd0, rsp.pready});
    compare("pslverr", {31'd0, bad_addr}, {31'd0, rsp.pslverr});
    @(posedge clk);
    req <= '0;
  endtask

  task automatic reg_write(input apb_pkg::addr_t addr, input apb_pkg::word_t wdata);
    apb_pkg::word_t unused;
    apb_xfer(1'b1, addr, wdata, unused);
    if (addr == `UART_ADDR_CTRL) ctrl_model = wdata & 32'hffff_0001;
    if (addr == `UART_ADDR_STATUS && wdata[2]) model_ovr = 1'b0;
  endtask

  task automatic reg_read(input apb_pkg::addr_t addr, output apb_pkg::word_t rdata);
    apb_xfer(1'b0, addr, '0, rdata);
  endtask

  task automatic send_bit(input logic b);
    rx_pin <= b;
    repeat (BIT_CLKS) @(posedge clk);
  endtask

  // start, data lsb first, optional parity, stop, then one idle bit.
  task automatic send_frame(input uart_pkg::data_t d, input logic with_par,
                            input logic par_bit, input logic stop_bit);
    send_bit(1'b0);
    for (int i = 0; i < 8; i++) send_bit(d[i]);
    if (with_par) send_bit(par_bit);
    send_bit(stop_bit);
    send_bit(1'b1);
  endtask

  task automatic send_modeled(input uart_pkg::data_t d, input logic with_par,
                              input logic flip, input logic stop_bit);
    logic par_bit;
    logic perr;
    par_bit = ~^d ^ flip;   // odd count of ones unless flipped.
    perr    = with_par && flip;
    if (model_q.size() < `UART_FIFO_DEPTH) begin
      model_q.push_back({21'd0, 1'b1, !stop_bit, perr, d});
    end else begin
      model_ovr = 1'b1;   // frame lost to a full FIFO.
    end
    send_frame(d, with_par, par_bit, stop_bit);
  endtask

  task automatic check_data;
    apb_pkg::word_t rd;
    apb_pkg::word_t exp;
    if (model_q.size() > 0) exp = model_q.pop_front();
    else exp = '0;
    reg_read(`UART_ADDR_DATA, rd);
    compare("data", exp, rd);
  endtask

  task automatic check_status;
    apb_pkg::word_t rd;
    reg_read(`UART_ADDR_STATUS, rd);
    compare("status", {29'd0, model_ovr, model_q.size() == `UART_FIFO_DEPTH,
                       model_q.size() == 0}, rd);
  endtask

  task automatic check_ctrl;
    apb_pkg::word_t rd;
    reg_read(`UART_ADDR_CTRL, rd);
    compare("ctrl", ctrl_model, rd);
  endtask

  // poll STATUS until one bit reaches the wanted level.
  task automatic wait_status_bit(input int idx, input logic level);
    apb_pkg::word_t rd;
    int tries;
    tries = 0;
    reg_read(`UART_ADDR_STATUS, rd);
    while (rd[idx] !== level && tries < 2 * BIT_CLKS) begin
      reg_read(`UART_ADDR_STATUS, rd);
      tries++;
    end
    if (rd[idx] !== level) begin
      other_errs++;
      $display("status bit %0d never reached %0b, frame did not arrive", idx, level);
    end
  endtask

  initial begin
    cycles = 0;
    while (cycles < TIMEOUT) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout after %0d cycles, run did not finish", cycles);
    $display("Test failures found");
    $finish;
  end

  initial begin
    int             r;
    apb_pkg::word_t rd;
    clk        = 1'b0;
    reset      = 1'b1;
    rx_pin     = 1'b1;
    req        = '0;
    seed       = 70839;
    checks     = 0;
    value_errs = 0;
    other_errs = 0;
    model_ovr  = 1'b0;
    ctrl_model = {`UART_DIV_RESET, 16'd0};
    repeat (5) @(posedge clk);
    reset <= 1'b0;

    check_ctrl;
    check_status;
    reg_write(`UART_ADDR_CTRL, {16'(DIV), 16'd0});
    check_ctrl;

    repeat (12) begin
      r = $random(seed);
      send_modeled(r[7:0], 1'b0, 1'b0, 1'b1);
      wait_status_bit(0, 1'b0);
      check_data;
    end

    // short low pulse rejected at the start bit check.
    rx_pin <= 1'b0;
    repeat (4) @(posedge clk);
    rx_pin <= 1'b1;
    repeat (12 * BIT_CLKS) @(posedge clk);   // longer than a whole frame.
    check_status;

    reg_write(`UART_ADDR_CTRL, {16'(DIV), 15'd0, 1'b1});
    check_ctrl;
    repeat (10) begin
      r = $random(seed);
      send_modeled(r[7:0], 1'b1, r[8], 1'b1);
      wait_status_bit(0, 1'b0);
      check_data;
    end

    reg_write(`UART_ADDR_CTRL, {16'(DIV), 16'd0});
    repeat (3) begin
      r = $random(seed);
      send_modeled(r[7:0], 1'b0, 1'b0, 1'b0);   // low stop bit.
      wait_status_bit(0, 1'b0);
      check_data;
    end

    repeat (`UART_FIFO_DEPTH + 2) begin
      r = $random(seed);
      send_modeled(r[7:0], 1'b0, 1'b0, 1'b1);
    end
    wait_status_bit(2, 1'b1);
    check_status;
    repeat (`UART_FIFO_DEPTH + 1) check_data;
    reg_write(`UART_ADDR_STATUS, 32'h0000_0004);
    check_status;

    // 0xc is outside the map.
    reg_read(12'h00c, rd);
    reg_write(12'h00c, 32'hffff_ffff);
    check_ctrl;

    $display("checks %0d, value errors %0d, other errors %0d",
             checks, value_errs, other_errs);
    if (value_errs + other_errs == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+hdl
hdl/uart_pkg.sv
hdl/apb_pkg.sv
hdl/baud_tick_gen.sv
hdl/uart_rx.sv
hdl/rx_fifo.sv
hdl/apb_uart_regs.sv
hdl/uart_apb_top.sv
verification/tb_uart_apb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_uart_apb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(wildcard hdl/*.sv hdl/*.svh verification/*.sv)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx 'All tests passed!'

clean:
	rm -rf $(OBJ_DIR)
